/* Makefile */
TOOL       = verilator
FLAGS      = --binary --timing --assert -Wno-fatal
LINT_FLAGS = --lint-only --timing -Wall
TOP        = tb_fir_top
FLIST      = fir_top.f
LOG        = sim.log

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST)

run: build
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "Testbench passed" $(LOG)

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf obj_dir $(LOG)

.PHONY: all build run lint clean

/* bench/fir_properties.sv */
`timescale 1ns/1ps

module fir_properties (
  input logic                       axis_clk,
  input logic                       axis_rst_n,
  input logic                       ss_tvalid,
  input logic                       ss_tready,
  input logic                       sm_tvalid,
  input logic                       sm_tready,
  input logic [fir_pkg::DATA_W-1:0] sm_tdata,
  input logic                       arready
);

  int fail_count = 0;

  // output beat holds under back-pressure
  assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
    sm_tvalid && !sm_tready |=> sm_tvalid && $stable(sm_tdata))
  else begin
    fail_count++;
    $error("sm_tvalid or sm_tdata changed while sm_tready was low");
  end

  assert property (@(posedge axis_clk) disable iff (!axis_rst_n) ss_tready |-> ss_tvalid)
  else begin
    fail_count++;
    $error("ss_tready high without ss_tvalid");
  end

  assert property (@(posedge axis_clk) disable iff (!axis_rst_n) arready |=> !arready)
  else begin
    fail_count++;
    $error("arready high for more than one cycle");
  end

endmodule

/* bench/fir_top_input.txt */
// first the tap count, then the coefficients c0..c3, then the sample count
// then one line per sample: input sample, tlast flag, expected output
00000004
00000001 00000002 00000003 00000004
00000008
00000001 0 00000001
00000002 0 00000004
00000003 0 0000000A
00000004 0 00000014
00000005 0 0000001E
00000010 0 00000032
80000000 0 8000003F
00000007 1 0000004B

/* bench/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock (
  output logic axis_clk,
  output logic axis_rst_n
);

  initial begin
    axis_clk = 1'b0;
    forever #20 axis_clk = ~axis_clk;   // 40 ns period
  end

  initial begin
    axis_rst_n = 1'b0;
    repeat (8) @(posedge axis_clk);
    #2;
    axis_rst_n = 1'b1;
  end

endmodule

/* bench/tb_fir_top.sv */
`timescale 1ns/1ps

module tb_fir_top;

  localparam int TIMEOUT = 200;   // cycles per wait

  logic                       axis_clk, axis_rst_n;
  logic                       awvalid, wvalid, awready, wready;
  logic [fir_pkg::ADDR_W-1:0] awaddr, araddr;
  logic [fir_pkg::DATA_W-1:0] wdata, rdata, ss_tdata, sm_tdata;
  logic                       arvalid, arready, rvalid, rready;
  logic                       ss_tvalid, ss_tlast, ss_tready;
  logic                       sm_tvalid, sm_tlast, sm_tready;

  logic [31:0] mem [64];   // image of the input file
  int          tap_count, sample_count, sample_base;
  int          err_count = 0;
  int          timeout_count = 0;
  logic [31:0] rng = 32'd96661;

  tb_clock u_clock (.axis_clk, .axis_rst_n);

  fir_top u_fir_top (.*);

  bind fir_top fir_properties u_properties (
    .axis_clk, .axis_rst_n, .ss_tvalid, .ss_tready, .sm_tvalid, .sm_tready, .sm_tdata,
    .arready
  );

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    return x ^ (x << 5);
  endfunction

  function automatic logic [fir_pkg::ADDR_W-1:0] coef_addr(input int k);
    return fir_pkg::ADDR_COEF_BASE + fir_pkg::ADDR_W'(4 * k);
  endfunction

  task automatic check_word(input logic [31:0] got, input logic [31:0] exp, input string what);
    assert (got === exp) else begin
      err_count++;
      $display("[ERROR] %0d ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic note_timeout(input string what);
    timeout_count++;
    $display("timed out at %0d ns waiting for %s", $time, what);
  endtask

  task automatic reg_write(input logic [fir_pkg::ADDR_W-1:0] addr,
                           input logic [fir_pkg::DATA_W-1:0] data);
    int n;
    @(posedge axis_clk);
    #2;
    awvalid = 1'b1;
    wvalid = 1'b1;
    awaddr = addr;
    wdata = data;
    #1;
    n = 0;
    while (!awready && n < TIMEOUT) begin
      @(posedge axis_clk);
      #3;
      n++;
    end
    assert (awready) else note_timeout("awready");
    check_word(32'(wready), 32'h1, "wready together with awready");
    @(posedge axis_clk);
    #2;
    awvalid = 1'b0;
    wvalid = 1'b0;
  endtask

  task automatic reg_read(input logic [fir_pkg::ADDR_W-1:0] addr,
                          output logic [fir_pkg::DATA_W-1:0] data);
    int n;
    @(posedge axis_clk);
    #2;
    arvalid = 1'b1;
    araddr = addr;
    rready = 1'b1;
    #1;
    n = 0;
    while (!arready && n < TIMEOUT) begin
      @(posedge axis_clk);
      #3;
      n++;
    end
    assert (arready) else note_timeout("arready");
    @(posedge axis_clk);
    #2;
    arvalid = 1'b0;
    #1;
    n = 0;
    while (!rvalid && n < TIMEOUT) begin
      @(posedge axis_clk);
      #3;
      n++;
    end
    assert (rvalid) else note_timeout("rvalid");
    data = rdata;
  endtask

  task automatic send_samples();
    int n;
    for (int i = 0; i < sample_count; i++) begin
      @(posedge axis_clk);
      #2;
      ss_tvalid = 1'b1;
      ss_tdata = mem[sample_base + 3 * i];
      ss_tlast = mem[sample_base + 3 * i + 1][0];
      #1;
      n = 0;
      while (!ss_tready && n < TIMEOUT) begin
        @(posedge axis_clk);
        #3;
        n++;
      end
      assert (ss_tready) else note_timeout("ss_tready");
    end
    @(posedge axis_clk);
    #2;
    ss_tvalid = 1'b0;
    ss_tlast = 1'b0;
  endtask

  // random sm_tready, one check per output beat
  task automatic collect_outputs();
    int   n;
    logic got;
    for (int i = 0; i < sample_count; i++) begin
      n = 0;
      got = 1'b0;
      while (!got && n < TIMEOUT) begin
        @(posedge axis_clk);
        #2;
        rng = xorshift(rng);
        sm_tready = rng[0];
        #1;
        got = sm_tvalid & sm_tready;
        n++;
      end
      assert (got) else note_timeout($sformatf("output %0d", i));
      check_word(sm_tdata, mem[sample_base + 3 * i + 2], $sformatf("sm_tdata of output %0d", i));
      check_word(32'(sm_tlast), mem[sample_base + 3 * i + 1],
                 $sformatf("sm_tlast of output %0d", i));
    end
    @(posedge axis_clk);
    #2;
    sm_tready = 1'b0;
  endtask

  task automatic probe_run();
    logic [31:0] rd;
    reg_read(fir_pkg::ADDR_AP_CTRL, rd);
    check_word(rd & (32'(1) << fir_pkg::AP_IDLE_BIT), 32'h0, "ap_idle during the run");
    reg_read(coef_addr(0), rd);
    check_word(rd, 32'hFFFF_FFFF, "coefficient read during the run");
    reg_write(coef_addr(1), 32'h0BAD_F00D);   // dropped while running
  endtask

  initial begin : main
    logic [31:0] rd;
    int          n;
    awvalid = 1'b0;
    awaddr = '0;
    wvalid = 1'b0;
    wdata = '0;
    arvalid = 1'b0;
    araddr = '0;
    rready = 1'b0;
    ss_tvalid = 1'b0;
    ss_tdata = '0;
    ss_tlast = 1'b0;
    sm_tready = 1'b0;
    $readmemh("bench/fir_top_input.txt", mem);
    tap_count = mem[0];
    sample_count = mem[tap_count + 1];
    sample_base = tap_count + 2;

    n = 0;
    while (!axis_rst_n && n < TIMEOUT) begin
      @(posedge axis_clk);
      n++;
    end
    assert (axis_rst_n) else note_timeout("reset release");

    reg_read(fir_pkg::ADDR_AP_CTRL, rd);
    check_word(rd, 32'(1) << fir_pkg::AP_IDLE_BIT, "ap_ctrl after reset");

    reg_write(fir_pkg::ADDR_TAP_NUM, mem[0]);
    for (int k = 0; k < tap_count; k++) begin
      reg_write(coef_addr(k), mem[1 + k]);
    end
    reg_read(fir_pkg::ADDR_TAP_NUM, rd);
    check_word(rd, mem[0], "tap count");
    for (int k = 0; k < tap_count; k++) begin
      reg_read(coef_addr(k), rd);
      check_word(rd, mem[1 + k], $sformatf("coefficient %0d", k));
    end

    reg_write(fir_pkg::ADDR_AP_CTRL, 32'h1);   // ap_start
    fork
      send_samples();
      collect_outputs();
      probe_run();
    join

    reg_read(fir_pkg::ADDR_AP_CTRL, rd);
    check_word(rd, (32'(1) << fir_pkg::AP_IDLE_BIT) | (32'(1) << fir_pkg::AP_DONE_BIT),
               "ap_ctrl after the run");
    reg_read(fir_pkg::ADDR_AP_CTRL, rd);
    check_word(rd, 32'(1) << fir_pkg::AP_IDLE_BIT, "ap_ctrl after done was read");
    reg_read(coef_addr(1), rd);
    check_word(rd, mem[2], "coefficient 1 after a write during the run");

    $display("value errors: %0d, timeouts: %0d, property failures: %0d",
             err_count, timeout_count, u_fir_top.u_properties.fail_count);
    if (err_count == 0 && timeout_count == 0 && u_fir_top.u_properties.fail_count == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

/* fir_top.f */
source/fir_pkg.sv
source/fir_cfg_regs.sv
source/fir_ctrl_fsm.sv
source/fir_tap_counter.sv
source/fir_sample_ring.sv
source/fir_mac.sv
source/fir_top.sv
bench/fir_properties.sv
bench/tb_clock.sv
bench/tb_fir_top.sv

/* source/fir_cfg_regs.sv */
`timescale 1ns/1ps

module fir_cfg_regs (
  input  logic                          axis_clk,
  input  logic                          axis_rst_n,
  input  logic                          awvalid,
  input  logic [fir_pkg::ADDR_W-1:0]    awaddr,
  input  logic                          wvalid,
  input  logic [fir_pkg::DATA_W-1:0]    wdata,
  output logic                          awready,
  output logic                          wready,
  input  logic                          arvalid,
  input  logic [fir_pkg::ADDR_W-1:0]    araddr,
  output logic                          arready,
  output logic                          rvalid,
  output logic [fir_pkg::DATA_W-1:0]    rdata,
  input  logic                          rready,
  input  logic                          running,
  input  logic                          done,
  input  logic [fir_pkg::TAP_IDX_W-1:0] coef_idx,
  output logic                          start,
  output logic [fir_pkg::TAP_IDX_W-1:0] tap_num,
  output logic [fir_pkg::DATA_W-1:0]    coef_rdata
);

  logic [fir_pkg::DATA_W-1:0] coef [fir_pkg::MAX_TAPS];
  logic                       wr_fire;
  logic                       done_q;
  logic [fir_pkg::DATA_W-1:0] rd_word;

  // 0x80..0xFC window
  function automatic logic is_coef(input logic [fir_pkg::ADDR_W-1:0] addr);
    return addr[fir_pkg::ADDR_W-1:2+fir_pkg::HIST_IDX_W] ==
           fir_pkg::ADDR_COEF_BASE[fir_pkg::ADDR_W-1:2+fir_pkg::HIST_IDX_W];
  endfunction

  assign wr_fire = awvalid & wvalid;
  assign awready = wr_fire;
  assign wready  = wr_fire;
  assign arready = arvalid & ~wr_fire & ~rvalid;   // writes win, one read in flight

  assign start = wr_fire & (awaddr == fir_pkg::ADDR_AP_CTRL) &
                 wdata[fir_pkg::AP_START_BIT] & ~running;

  always_ff @(posedge axis_clk or negedge axis_rst_n) begin
    if (!axis_rst_n) begin
      tap_num <= '0;
    end else if (wr_fire && !running && awaddr == fir_pkg::ADDR_TAP_NUM) begin
      if (wdata > fir_pkg::MAX_TAPS) begin
        tap_num <= fir_pkg::TAP_IDX_W'(fir_pkg::MAX_TAPS);   // clamp
      end else begin
        tap_num <= wdata[fir_pkg::TAP_IDX_W-1:0];
      end
    end
  end

  always_ff @(posedge axis_clk) begin
    if (wr_fire && !running && is_coef(awaddr)) begin
      coef[awaddr[2 +: fir_pkg::HIST_IDX_W]] <= wdata;
    end
  end

  assign coef_rdata = coef[coef_idx[fir_pkg::HIST_IDX_W-1:0]];

  // done is sticky until software reads it back
  always_ff @(posedge axis_clk or negedge axis_rst_n) begin
    if (!axis_rst_n) begin
      done_q <= 1'b0;
    end else if (done) begin
      done_q <= 1'b1;
    end else if (arready && araddr == fir_pkg::ADDR_AP_CTRL) begin
      done_q <= 1'b0;
    end
  end

  always_comb begin
    rd_word = '0;
    if (araddr == fir_pkg::ADDR_AP_CTRL) begin
      rd_word[fir_pkg::AP_DONE_BIT] = done_q;
      rd_word[fir_pkg::AP_IDLE_BIT] = ~running;
    end else if (araddr == fir_pkg::ADDR_TAP_NUM) begin
      rd_word = fir_pkg::DATA_W'(tap_num);
    end else if (is_coef(araddr)) begin
      rd_word = running ? fir_pkg::READ_BUSY_VALUE : coef[araddr[2 +: fir_pkg::HIST_IDX_W]];
    end
  end

  always_ff @(posedge axis_clk or negedge axis_rst_n) begin
    if (!axis_rst_n) begin
      rvalid <= 1'b0;
    end else if (arready) begin
      rvalid <= 1'b1;
    end else if (rready) begin
      rvalid <= 1'b0;
    end
  end

  always_ff @(posedge axis_clk) begin
    if (arready) begin
      rdata <= rd_word;
    end
  end

endmodule

/* source/fir_ctrl_fsm.sv */
`timescale 1ns/1ps

module fir_ctrl_fsm (
  input  logic axis_clk,
  input  logic axis_rst_n,
  input  logic start,
  input  logic ss_tvalid,
  input  logic ss_tlast,
  input  logic sm_tready,
  input  logic tap_last,
  input  logic acc_valid,
  output logic ss_tready,
  output logic push,
  output logic cnt_clear,
  output logic cnt_en,
  output logic mac_clear,
  output logic mac_en,
  output logic sm_tvalid,
  output logic sm_tlast,
  output logic running,
  output logic done
);

  fir_pkg::fir_state_e state, state_nxt;
  logic                last_q;   // tlast of the sample in flight

  always_ff @(posedge axis_clk or negedge axis_rst_n) begin
    if (!axis_rst_n) begin
      state <= fir_pkg::IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  always_comb begin
    state_nxt = state;
    case (state)
      fir_pkg::IDLE:  if (start) state_nxt = fir_pkg::LOAD;
      fir_pkg::LOAD:  if (ss_tvalid) state_nxt = fir_pkg::CALC;
      fir_pkg::CALC:  if (tap_last) state_nxt = fir_pkg::DRAIN;
      fir_pkg::DRAIN: if (acc_valid) state_nxt = fir_pkg::EMIT;
      fir_pkg::EMIT: begin
        if (sm_tready) begin
          state_nxt = last_q ? fir_pkg::IDLE : fir_pkg::LOAD;
        end
      end
      default: state_nxt = fir_pkg::IDLE;
    endcase
  end

  always_ff @(posedge axis_clk or negedge axis_rst_n) begin
    if (!axis_rst_n) begin
      last_q <= 1'b0;
    end else if (push) begin
      last_q <= ss_tlast;
    end
  end

  assign ss_tready = (state == fir_pkg::LOAD) & ss_tvalid;
  assign push      = ss_tready;
  assign cnt_clear = (state == fir_pkg::LOAD);
  assign mac_clear = (state == fir_pkg::LOAD);
  assign cnt_en    = (state == fir_pkg::CALC);
  assign mac_en    = (state == fir_pkg::CALC);
  assign sm_tvalid = (state == fir_pkg::EMIT);
  assign sm_tlast  = sm_tvalid & last_q;
  assign running   = (state != fir_pkg::IDLE);
  assign done      = sm_tvalid & sm_tready & last_q;

endmodule

/* source/fir_mac.sv */
`timescale 1ns/1ps

module fir_mac (
  input  logic                       axis_clk,
  input  logic                       axis_rst_n,
  input  logic                       mac_clear,
  input  logic                       mac_en,
  input  logic                       mac_last,
  input  logic [fir_pkg::DATA_W-1:0] sample,
  input  logic [fir_pkg::DATA_W-1:0] coef,
  output logic [fir_pkg::DATA_W-1:0] acc,
  output logic                       acc_valid
);

  logic [fir_pkg::DATA_W-1:0]      op_a, op_b, prod;
  logic [fir_pkg::MAC_LATENCY-1:0] vld_pipe, last_pipe;   // bit 0 operands, bit 1 product

  always_ff @(posedge axis_clk or negedge axis_rst_n) begin
    if (!axis_rst_n) begin
      vld_pipe  <= '0;
      last_pipe <= '0;
      acc_valid <= 1'b0;
    end else if (mac_clear) begin
      vld_pipe  <= '0;
      last_pipe <= '0;
      acc_valid <= 1'b0;
    end else begin
      vld_pipe  <= {vld_pipe[fir_pkg::MAC_LATENCY-2:0], mac_en};
      last_pipe <= {last_pipe[fir_pkg::MAC_LATENCY-2:0], mac_en & mac_last};
      acc_valid <= vld_pipe[fir_pkg::MAC_LATENCY-1] & last_pipe[fir_pkg::MAC_LATENCY-1];
    end
  end

  always_ff @(posedge axis_clk) begin
    op_a <= sample;
    op_b <= coef;
    prod <= fir_pkg::DATA_W'(op_a * op_b);   // low word only
    if (mac_clear) begin
      acc <= '0;
    end else if (vld_pipe[fir_pkg::MAC_LATENCY-1]) begin
      acc <= acc + prod;
    end
  end

endmodule

/* source/fir_pkg.sv */
package fir_pkg;

  // datapath and bus widths
  localparam int DATA_W = 32;
  localparam int ADDR_W = 12;

  localparam int MAX_TAPS = 32;
  localparam int TAP_IDX_W = 6;                   // holds 0..32
  localparam int HIST_IDX_W = $clog2(MAX_TAPS);   // ring and coef index

  // register map
  localparam logic [ADDR_W-1:0] ADDR_AP_CTRL = 12'h000;
  localparam logic [ADDR_W-1:0] ADDR_TAP_NUM = 12'h014;
  localparam logic [ADDR_W-1:0] ADDR_COEF_BASE = 12'h080;   // coef k at base + 4k

  // ap_ctrl bits
  localparam int AP_START_BIT = 0;
  localparam int AP_DONE_BIT = 1;
  localparam int AP_IDLE_BIT = 2;

  localparam logic [DATA_W-1:0] READ_BUSY_VALUE = '1;

  localparam int MAC_LATENCY = 2;   // operand reg + product reg

  typedef enum logic [2:0] {
    IDLE,
    LOAD,
    CALC,
    DRAIN,
    EMIT
  } fir_state_e;

endpackage

/* source/fir_sample_ring.sv */
`timescale 1ns/1ps

module fir_sample_ring (
  input  logic                          axis_clk,
  input  logic                          axis_rst_n,
  input  logic                          clear,
  input  logic                          push,
  input  logic [fir_pkg::DATA_W-1:0]    ss_tdata,
  input  logic [fir_pkg::TAP_IDX_W-1:0] tap_idx,
  output logic [fir_pkg::DATA_W-1:0]    tap_sample
);

  logic [fir_pkg::DATA_W-1:0]     hist [fir_pkg::MAX_TAPS];
  logic [fir_pkg::HIST_IDX_W-1:0] head;     // newest entry
  logic [fir_pkg::HIST_IDX_W-1:0] wr_ptr;

  assign wr_ptr = head + 1'b1;

  always_ff @(posedge axis_clk or negedge axis_rst_n) begin
    if (!axis_rst_n) begin
      head <= '0;
    end else if (clear) begin
      head <= '0;
    end else if (push) begin
      head <= wr_ptr;
    end
  end

  // history before the run reads as zero
  always_ff @(posedge axis_clk) begin
    if (clear) begin
      for (int i = 0; i < fir_pkg::MAX_TAPS; i++) begin
        hist[i] <= '0;
      end
    end else if (push) begin
      hist[wr_ptr] <= ss_tdata;
    end
  end

  assign tap_sample = hist[head - tap_idx[fir_pkg::HIST_IDX_W-1:0]];   // wraps mod depth

endmodule

/* source/fir_tap_counter.sv */
`timescale 1ns/1ps

module fir_tap_counter (
  input  logic                          axis_clk,
  input  logic                          axis_rst_n,
  input  logic                          cnt_clear,
  input  logic                          cnt_en,
  input  logic [fir_pkg::TAP_IDX_W-1:0] tap_num,
  output logic [fir_pkg::TAP_IDX_W-1:0] tap_idx,
  output logic                          tap_last
);

  logic [fir_pkg::TAP_IDX_W-1:0] last_idx;

  // zero taps behaves like a single tap
  assign last_idx = (tap_num == '0) ? '0 : tap_num - fir_pkg::TAP_IDX_W'(1);
  assign tap_last = (tap_idx == last_idx);

  always_ff @(posedge axis_clk or negedge axis_rst_n) begin
    if (!axis_rst_n) begin
      tap_idx <= '0;
    end else if (cnt_clear) begin
      tap_idx <= '0;
    end else if (cnt_en) begin
      tap_idx <= tap_last ? '0 : tap_idx + fir_pkg::TAP_IDX_W'(1);
    end
  end

endmodule

/* source/fir_top.sv */
`timescale 1ns/1ps

module fir_top (
  input  logic                       axis_clk,
  input  logic                       axis_rst_n,
  input  logic                       awvalid,
  input  logic [fir_pkg::ADDR_W-1:0] awaddr,
  input  logic                       wvalid,
  input  logic [fir_pkg::DATA_W-1:0] wdata,
  output logic                       awready,
  output logic                       wready,
  input  logic                       arvalid,
  input  logic [fir_pkg::ADDR_W-1:0] araddr,
  output logic                       arready,
  output logic                       rvalid,
  output logic [fir_pkg::DATA_W-1:0] rdata,
  input  logic                       rready,
  input  logic                       ss_tvalid,
  input  logic [fir_pkg::DATA_W-1:0] ss_tdata,
  input  logic                       ss_tlast,
  output logic                       ss_tready,
  output logic                       sm_tvalid,
  output logic [fir_pkg::DATA_W-1:0] sm_tdata,
  output logic                       sm_tlast,
  input  logic                       sm_tready
);

  logic                          start, running, done, push;
  logic                          cnt_clear, cnt_en, mac_clear, mac_en;
  logic                          tap_last, acc_valid;
  logic [fir_pkg::TAP_IDX_W-1:0] tap_num, tap_idx;
  logic [fir_pkg::DATA_W-1:0]    coef_rdata, tap_sample;

  fir_cfg_regs u_cfg_regs (
    .axis_clk, .axis_rst_n, .awvalid, .awaddr, .wvalid, .wdata, .awready, .wready,
    .arvalid, .araddr, .arready, .rvalid, .rdata, .rready, .running, .done,
    .coef_idx(tap_idx), .start, .tap_num, .coef_rdata
  );

  fir_ctrl_fsm u_ctrl_fsm (
    .axis_clk, .axis_rst_n, .start, .ss_tvalid, .ss_tlast, .sm_tready, .tap_last,
    .acc_valid, .ss_tready, .push, .cnt_clear, .cnt_en, .mac_clear, .mac_en,
    .sm_tvalid, .sm_tlast, .running, .done
  );

  fir_tap_counter u_tap_counter (
    .axis_clk, .axis_rst_n, .cnt_clear, .cnt_en, .tap_num, .tap_idx, .tap_last
  );

  // history is wiped on every start
  fir_sample_ring u_sample_ring (
    .axis_clk, .axis_rst_n, .clear(start), .push, .ss_tdata, .tap_idx, .tap_sample
  );

  fir_mac u_mac (
    .axis_clk, .axis_rst_n, .mac_clear, .mac_en, .mac_last(tap_last),
    .sample(tap_sample), .coef(coef_rdata), .acc(sm_tdata), .acc_valid
  );

endmodule
